/* hw/flush_sequencer.sv */
`timescale 1ns/1ps

module flush_sequencer
   import mem_bridge_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic l1i_flush_req,
   input  logic l1d_flush_req,
   input  logic l1i_flush_complete,
   input  logic l1d_flush_complete,
   input  logic l2_flush_complete,
   output logic in_flush_mode,
   output logic l2_flush_req
);

   flush_state_t r_state;
   flush_state_t n_state;
   logic r_flush;
   logic n_flush;
   logic r_flush_l2;
   logic n_flush_l2;

   assign in_flush_mode = r_flush;
   assign l2_flush_req = r_flush_l2;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= FLUSH_IDLE;
         r_flush <= 1'b0;
         r_flush_l2 <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_flush <= n_flush;
         r_flush_l2 <= n_flush_l2;
      end
   end

   always_comb
   begin
      n_state = r_state;
      n_flush = r_flush;
      n_flush_l2 = 1'b0;

      case (r_state)
         FLUSH_IDLE:
         begin
            if (l1i_flush_req && l1d_flush_req)
            begin
               n_state = WAIT_FOR_L1D_L1I;
               n_flush = 1'b1;
            end
            else if (l1i_flush_req)
            begin
               // only the icache owes a complete
               n_state = GOT_L1D;
               n_flush = 1'b1;
            end
            else if (l1d_flush_req)
            begin
               n_state = GOT_L1I;
               n_flush = 1'b1;
            end
         end
         WAIT_FOR_L1D_L1I:
         begin
            if (l1d_flush_complete && l1i_flush_complete)
            begin
               n_state = FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
            else if (l1d_flush_complete)
            begin
               n_state = GOT_L1D;
            end
            else if (l1i_flush_complete)
            begin
               n_state = GOT_L1I;
            end
         end
         GOT_L1D:
         begin
            if (l1i_flush_complete)
            begin
               n_state = FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
         end
         GOT_L1I:
         begin
            if (l1d_flush_complete)
            begin
               n_state = FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
         end
         FLUSH_L2:
         begin
            // stay in flush mode until the l2 is clean
            if (l2_flush_complete)
            begin
               n_state = FLUSH_IDLE;
               n_flush = 1'b0;
            end
         end
         default:
         begin
            n_state = FLUSH_IDLE;
            n_flush = 1'b0;
         end
      endcase
   end

endmodule

/* hw/mem_bridge_pkg.sv */
`include "mem_bridge_defines.svh"

package mem_bridge_pkg;

   typedef logic [`MEM_PA_WIDTH-1:0] pa_t;
   typedef logic [`MEM_LG_REQ_TAGS-1:0] mem_tag_t;
   typedef logic [(1 << (`MEM_LG_CL_BYTES + 3))-1:0] cache_line_t;
   typedef logic [`MEM_OPCODE_WIDTH-1:0] mem_opcode_t;

   // l2 to memory request
   typedef struct packed {
      pa_t         addr;
      mem_tag_t    tag;
      cache_line_t data;
      mem_opcode_t opcode;
   } mem_req_t;

   // memory response returned to l2
   typedef struct packed {
      mem_tag_t    tag;
      cache_line_t data;
   } mem_rsp_t;

   // GOT_L1D and GOT_L1I name the cache already done,
   // so the other one still owes its complete
   typedef enum logic [2:0] {
      FLUSH_IDLE       = 3'd0,
      WAIT_FOR_L1D_L1I = 3'd1,
      GOT_L1D          = 3'd2,
      GOT_L1I          = 3'd3,
      FLUSH_L2         = 3'd4
   } flush_state_t;

   typedef enum logic [1:0] {
      ISSUE_IDLE         = 2'd0,
      ISSUE_WAIT_RSP     = 2'd1,
      ISSUE_WAIT_RSP_LOW = 2'd2
   } issue_state_t;

endpackage

/* hw/mem_bridge_top.sv */
`timescale 1ns/1ps

module mem_bridge_top
   import mem_bridge_pkg::*;
(
   input  logic        clk,
   input  logic        reset,

   // flush handshake with the caches
   input  logic        l1i_flush_req,
   input  logic        l1d_flush_req,
   input  logic        l1i_flush_complete,
   input  logic        l1d_flush_complete,
   input  logic        l2_flush_complete,
   output logic        in_flush_mode,
   output logic        l2_flush_req,

   // l2 side
   input  logic        l2_req_valid,
   input  mem_req_t    l2_req,
   output logic        l2_req_ready,
   output logic        l2_rsp_valid,
   output mem_rsp_t    l2_rsp,

   // memory side
   output logic        mem_req_valid,
   output mem_req_t    mem_req,
   input  logic        mem_req_gnt,
   input  logic        mem_rsp_valid,
   input  cache_line_t mem_rsp_data,

   output logic        bad_rsp
);

   mem_req_t queue_head;
   logic queue_empty;
   logic queue_pop;

   // memory always sees the oldest entry
   assign mem_req = queue_head;

   flush_sequencer u_flush_sequencer (
      .clk                (clk),
      .reset              (reset),
      .l1i_flush_req      (l1i_flush_req),
      .l1d_flush_req      (l1d_flush_req),
      .l1i_flush_complete (l1i_flush_complete),
      .l1d_flush_complete (l1d_flush_complete),
      .l2_flush_complete  (l2_flush_complete),
      .in_flush_mode      (in_flush_mode),
      .l2_flush_req       (l2_flush_req)
   );

   mem_req_queue u_mem_req_queue (
      .clk          (clk),
      .reset        (reset),
      .l2_req_valid (l2_req_valid),
      .l2_req       (l2_req),
      .queue_pop    (queue_pop),
      .l2_req_ready (l2_req_ready),
      .queue_head   (queue_head),
      .queue_empty  (queue_empty)
   );

   mem_req_issuer u_mem_req_issuer (
      .clk           (clk),
      .reset         (reset),
      .queue_empty   (queue_empty),
      .queue_head    (queue_head),
      .mem_req_gnt   (mem_req_gnt),
      .mem_rsp_valid (mem_rsp_valid),
      .mem_rsp_data  (mem_rsp_data),
      .queue_pop     (queue_pop),
      .mem_req_valid (mem_req_valid),
      .l2_rsp_valid  (l2_rsp_valid),
      .l2_rsp        (l2_rsp),
      .bad_rsp       (bad_rsp)
   );

endmodule

/* hw/mem_req_issuer.sv */
`timescale 1ns/1ps

module mem_req_issuer
   import mem_bridge_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        queue_empty,
   input  mem_req_t    queue_head,
   input  logic        mem_req_gnt,
   input  logic        mem_rsp_valid,
   input  cache_line_t mem_rsp_data,
   output logic        queue_pop,
   output logic        mem_req_valid,
   output logic        l2_rsp_valid,
   output mem_rsp_t    l2_rsp,
   output logic        bad_rsp
);

   issue_state_t r_state;
   issue_state_t n_state;
   logic r_req_valid;
   logic n_req_valid;
   logic r_rsp_valid;
   logic n_rsp_valid;
   logic r_error;
   logic n_error;
   mem_tag_t r_tag;
   mem_tag_t n_tag;
   cache_line_t r_data;
   cache_line_t n_data;

   assign mem_req_valid = r_req_valid;
   assign l2_rsp_valid = r_rsp_valid;
   assign bad_rsp = r_error;
   assign l2_rsp.tag = r_tag;
   assign l2_rsp.data = r_data;

   // head retires on the response edge
   assign queue_pop = (r_state == ISSUE_WAIT_RSP) && mem_rsp_valid;

   always_comb
   begin
      n_state = r_state;
      n_req_valid = r_req_valid;
      n_rsp_valid = 1'b0;
      n_tag = r_tag;
      n_data = r_data;
      // response with nobody waiting
      n_error = r_error || (mem_rsp_valid && (r_state != ISSUE_WAIT_RSP));

      case (r_state)
         ISSUE_IDLE:
         begin
            if (!queue_empty)
            begin
               n_state = ISSUE_WAIT_RSP;
               n_req_valid = 1'b1;
               n_tag = queue_head.tag;
            end
         end
         ISSUE_WAIT_RSP:
         begin
            // grant only drops valid, the response retires
            if (mem_req_gnt)
            begin
               n_req_valid = 1'b0;
            end
            if (mem_rsp_valid)
            begin
               n_state = ISSUE_WAIT_RSP_LOW;
               n_req_valid = 1'b0;
               n_rsp_valid = 1'b1;
               n_data = mem_rsp_data;
            end
         end
         ISSUE_WAIT_RSP_LOW:
         begin
            if (!mem_rsp_valid)
            begin
               n_state = ISSUE_IDLE;
            end
         end
         default:
         begin
            n_state = ISSUE_IDLE;
            n_req_valid = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= ISSUE_IDLE;
         r_req_valid <= 1'b0;
         r_rsp_valid <= 1'b0;
         r_error <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_req_valid <= n_req_valid;
         r_rsp_valid <= n_rsp_valid;
         r_error <= n_error;
      end
   end

   always_ff @(posedge clk)
   begin
      r_tag <= n_tag;
      r_data <= n_data;
   end

endmodule

/* hw/mem_req_queue.sv */
`timescale 1ns/1ps

`include "mem_bridge_defines.svh"

module mem_req_queue
   import mem_bridge_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     l2_req_valid,
   input  mem_req_t l2_req,
   input  logic     queue_pop,
   output logic     l2_req_ready,
   output mem_req_t queue_head,
   output logic     queue_empty
);

   localparam int DEPTH = 1 << `MEM_LG_QUEUE_DEPTH;

   // extra top bit tells full from empty
   typedef logic [`MEM_LG_QUEUE_DEPTH:0] q_ptr_t;

   mem_req_t mem [DEPTH];

   q_ptr_t r_head_ptr;
   q_ptr_t r_tail_ptr;
   q_ptr_t n_head_ptr;
   q_ptr_t n_tail_ptr;
   logic [`MEM_LG_QUEUE_DEPTH-1:0] head_idx;
   logic [`MEM_LG_QUEUE_DEPTH-1:0] tail_idx;
   logic full;
   logic push;
   logic pop;

   assign head_idx = r_head_ptr[`MEM_LG_QUEUE_DEPTH-1:0];
   assign tail_idx = r_tail_ptr[`MEM_LG_QUEUE_DEPTH-1:0];

   assign queue_empty = (r_head_ptr == r_tail_ptr);
   assign full = (head_idx == tail_idx) &&
                 (r_head_ptr[`MEM_LG_QUEUE_DEPTH] != r_tail_ptr[`MEM_LG_QUEUE_DEPTH]);

   assign l2_req_ready = !full;
   assign push = l2_req_valid && !full;
   assign pop = queue_pop && !queue_empty;

   assign queue_head = mem[head_idx];

   always_comb
   begin
      n_head_ptr = r_head_ptr;
      n_tail_ptr = r_tail_ptr;
      if (push)
      begin
         n_tail_ptr = r_tail_ptr + q_ptr_t'(1);
      end
      if (pop)
      begin
         n_head_ptr = r_head_ptr + q_ptr_t'(1);
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_head_ptr <= '0;
         r_tail_ptr <= '0;
      end
      else
      begin
         r_head_ptr <= n_head_ptr;
         r_tail_ptr <= n_tail_ptr;
      end
   end

   // entry storage
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem[tail_idx] <= l2_req;
      end
   end

endmodule

/* include/mem_bridge_defines.svh */
`ifndef MEM_BRIDGE_DEFINES_SVH
`define MEM_BRIDGE_DEFINES_SVH

// physical address bits
`define MEM_PA_WIDTH 32

// log2 of outstanding request tags
`define MEM_LG_REQ_TAGS 2

// log2 of bytes per cache line, 16 bytes
`define MEM_LG_CL_BYTES 4

// memory opcode bits
`define MEM_OPCODE_WIDTH 4

// queue holds twice the tag count
`define MEM_LG_QUEUE_DEPTH (`MEM_LG_REQ_TAGS + 1)

`endif

/* mem_bridge.f */
+incdir+include
hw/mem_bridge_pkg.sv
hw/flush_sequencer.sv
hw/mem_req_queue.sv
hw/mem_req_issuer.sv
hw/mem_bridge_top.sv
verif/mem_bridge_tb.sv

/* verif/mem_bridge_tb.sv */
`timescale 1ns/1ps

`include "mem_bridge_defines.svh"

module mem_bridge_tb
   import mem_bridge_pkg::*;
();

   localparam int CLK_PERIOD = 4;
   localparam int RESET_CYCLES = 16;
   localparam int N_REQ = 64;
   localparam int N_FLUSH = 16;
   localparam int MAX_LAT = 12;
   localparam int QUEUE_DEPTH = 1 << `MEM_LG_QUEUE_DEPTH;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + (N_REQ + QUEUE_DEPTH + 1) * (MAX_LAT + 8) +
                                    N_FLUSH * 32 + 200;

   logic clk;
   logic reset;
   logic l1i_flush_req;
   logic l1d_flush_req;
   logic l1i_flush_complete;
   logic l1d_flush_complete;
   logic l2_flush_complete;
   logic in_flush_mode;
   logic l2_flush_req;
   logic l2_req_valid;
   mem_req_t l2_req;
   logic l2_req_ready;
   logic mem_req_valid;
   mem_req_t mem_req;
   logic mem_req_gnt;
   logic mem_rsp_valid;
   cache_line_t mem_rsp_data;
   logic l2_rsp_valid;
   mem_rsp_t l2_rsp;
   logic bad_rsp;

   integer seed = 32'hc05aba04;

   // memory agent control and state
   logic mem_stall;
   logic inject_rsp;
   logic mem_busy;
   logic mem_granted;
   int mem_delay;

   // reference model state
   mem_req_t model_q[$];
   logic issued;
   logic dropped;
   logic must_fall;
   logic rsp_due;
   mem_rsp_t exp_rsp;
   logic bad_exp;
   logic f_active;
   logic f_need_i;
   logic f_need_d;
   logic f_wait_l2;
   logic exp_flush_mode;
   logic exp_l2_flush;

   mem_bridge_top UUT (
      .clk                (clk),
      .reset              (reset),
      .l1i_flush_req      (l1i_flush_req),
      .l1d_flush_req      (l1d_flush_req),
      .l1i_flush_complete (l1i_flush_complete),
      .l1d_flush_complete (l1d_flush_complete),
      .l2_flush_complete  (l2_flush_complete),
      .in_flush_mode      (in_flush_mode),
      .l2_flush_req       (l2_flush_req),
      .l2_req_valid       (l2_req_valid),
      .l2_req             (l2_req),
      .l2_req_ready       (l2_req_ready),
      .l2_rsp_valid       (l2_rsp_valid),
      .l2_rsp             (l2_rsp),
      .mem_req_valid      (mem_req_valid),
      .mem_req            (mem_req),
      .mem_req_gnt        (mem_req_gnt),
      .mem_rsp_valid      (mem_rsp_valid),
      .mem_rsp_data       (mem_rsp_data),
      .bad_rsp            (bad_rsp)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic report_mismatch(input string name, input logic [255:0] expected,
                                  input logic [255:0] actual);
      $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
      $display("test failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_failure(input string what);
      $display("%0t %s", $time, what);
      $display("test failed");
      $fatal(1, "stopped at first error");
   endtask

   function automatic int rand_range(input int lo, input int hi);
      return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
   endfunction

   function automatic cache_line_t random_line();
      cache_line_t line;
      int i;
      for (i = 0; i < $bits(cache_line_t) / 32; i++)
         line[i*32 +: 32] = $random(seed);
      return line;
   endfunction

   function automatic mem_req_t random_req();
      mem_req_t req;
      req.addr = $random(seed);
      req.tag = mem_tag_t'(rand_range(0, 3));
      req.data = random_line();
      req.opcode = mem_opcode_t'($random(seed));
      return req;
   endfunction

   // memory agent, one outstanding request with random grant and latency
   always @(posedge clk)
   begin
      if (reset)
      begin
         mem_req_gnt <= 1'b0;
         mem_rsp_valid <= 1'b0;
         mem_busy = 1'b0;
         mem_granted = 1'b0;
      end
      else
      begin
         mem_req_gnt <= 1'b0;
         mem_rsp_valid <= 1'b0;
         if (inject_rsp)
         begin
            mem_rsp_valid <= 1'b1;
            mem_rsp_data <= random_line();
         end
         else if (!mem_busy)
         begin
            if (mem_req_valid && !mem_stall)
            begin
               mem_busy = 1'b1;
               mem_granted = 1'b0;
               mem_delay = rand_range(1, MAX_LAT);
            end
         end
         else if (mem_rsp_valid)
            mem_busy = 1'b0;
         else
         begin
            if (mem_req_valid && !mem_granted && rand_range(0, 3) == 0)
            begin
               mem_req_gnt <= 1'b1;
               mem_granted = 1'b1;
            end
            mem_delay = mem_delay - 1;
            if (mem_delay == 0)
            begin
               mem_rsp_valid <= 1'b1;
               mem_rsp_data <= random_line();
            end
         end
      end
   end

   // monitor and reference model, sees values as the DUT samples them
   always @(posedge clk)
   begin
      if (reset)
      begin
         model_q.delete();
         issued = 1'b0;
         dropped = 1'b0;
         must_fall = 1'b0;
         rsp_due = 1'b0;
         bad_exp = 1'b0;
         f_active = 1'b0;
         f_need_i = 1'b0;
         f_need_d = 1'b0;
         f_wait_l2 = 1'b0;
         exp_flush_mode = 1'b0;
         exp_l2_flush = 1'b0;
      end
      else
      begin
         assert (in_flush_mode == exp_flush_mode)
            else report_mismatch("in_flush_mode", exp_flush_mode, in_flush_mode);
         assert (l2_flush_req == exp_l2_flush)
            else report_mismatch("l2_flush_req", exp_l2_flush, l2_flush_req);
         assert (bad_rsp == bad_exp)
            else report_mismatch("bad_rsp", bad_exp, bad_rsp);
         assert (l2_req_ready == (model_q.size() < QUEUE_DEPTH))
            else report_mismatch("l2_req_ready", model_q.size() < QUEUE_DEPTH, l2_req_ready);
         if (rsp_due)
         begin
            assert (l2_rsp_valid)
               else report_mismatch("l2_rsp_valid", 1'b1, l2_rsp_valid);
            assert (l2_rsp == exp_rsp)
               else report_mismatch("l2_rsp", exp_rsp, l2_rsp);
         end
         else
         begin
            assert (!l2_rsp_valid)
               else report_failure("l2_rsp_valid pulsed with no response due");
         end
         if (must_fall)
         begin
            assert (!mem_req_valid)
               else report_failure("mem_req_valid still high after grant or response");
         end
         if (mem_req_valid)
         begin
            assert (!dropped)
               else report_failure("second memory request before the response");
            assert (model_q.size() > 0)
               else report_failure("memory request with no accepted request");
            assert (mem_req == model_q[0])
               else report_mismatch("mem_req", model_q[0], mem_req);
         end

         // memory side update
         rsp_due = 1'b0;
         must_fall = mem_req_valid && (mem_req_gnt || mem_rsp_valid);
         if (mem_rsp_valid && issued)
         begin
            exp_rsp.tag = model_q[0].tag;
            exp_rsp.data = mem_rsp_data;
            void'(model_q.pop_front());
            rsp_due = 1'b1;
            issued = 1'b0;
            dropped = 1'b0;
         end
         else if (mem_rsp_valid)
            bad_exp = 1'b1;
         else if (mem_req_valid && !issued)
            issued = 1'b1;
         else if (issued && !mem_req_valid)
            dropped = 1'b1;
         if (l2_req_valid && l2_req_ready)
            model_q.push_back(l2_req);

         // flush ordering
         exp_l2_flush = 1'b0;
         if (!f_active)
         begin
            if (l1i_flush_req || l1d_flush_req)
            begin
               f_active = 1'b1;
               f_need_i = l1i_flush_req;
               f_need_d = l1d_flush_req;
            end
         end
         else if (!f_wait_l2)
         begin
            if (l1i_flush_complete)
               f_need_i = 1'b0;
            if (l1d_flush_complete)
               f_need_d = 1'b0;
            if (!f_need_i && !f_need_d)
            begin
               f_wait_l2 = 1'b1;
               exp_l2_flush = 1'b1;
            end
         end
         else if (l2_flush_complete)
         begin
            f_active = 1'b0;
            f_wait_l2 = 1'b0;
         end
         exp_flush_mode = f_active;
      end
   end

   task automatic check_reset_outputs();
      assert (!in_flush_mode) else report_mismatch("in_flush_mode", 1'b0, in_flush_mode);
      assert (!l2_flush_req) else report_mismatch("l2_flush_req", 1'b0, l2_flush_req);
      assert (!mem_req_valid) else report_mismatch("mem_req_valid", 1'b0, mem_req_valid);
      assert (!l2_rsp_valid) else report_mismatch("l2_rsp_valid", 1'b0, l2_rsp_valid);
      assert (!bad_rsp) else report_mismatch("bad_rsp", 1'b0, bad_rsp);
      assert (l2_req_ready) else report_mismatch("l2_req_ready", 1'b1, l2_req_ready);
   endtask

   // called on a rising edge, returns on the edge of the transfer
   task automatic push_req(input mem_req_t req);
      l2_req_valid <= 1'b1;
      l2_req <= req;
      @(posedge clk);
      while (!l2_req_ready)
         @(posedge clk);
      l2_req_valid <= 1'b0;
   endtask

   task automatic wait_drain();
      while (model_q.size() != 0 || issued)
         @(posedge clk);
      repeat (4) @(posedge clk);
   endtask

   task automatic pulse_complete(input logic icache, input logic dcache);
      l1i_flush_complete <= icache;
      l1d_flush_complete <= dcache;
      @(posedge clk);
      l1i_flush_complete <= 1'b0;
      l1d_flush_complete <= 1'b0;
   endtask

   // kind 0 icache, 1 dcache, 2 both; order 0 icache first, 1 dcache first, 2 together
   task automatic run_flush(input int kind, input int order);
      l1i_flush_req <= (kind != 1);
      l1d_flush_req <= (kind != 0);
      @(posedge clk);
      l1i_flush_req <= 1'b0;
      l1d_flush_req <= 1'b0;
      repeat (rand_range(0, 3)) @(posedge clk);
      if (kind == 0)
         pulse_complete(1'b1, 1'b0);
      else if (kind == 1)
         pulse_complete(1'b0, 1'b1);
      else if (order == 2)
         pulse_complete(1'b1, 1'b1);
      else
      begin
         pulse_complete(order == 0, order == 1);
         repeat (rand_range(0, 3)) @(posedge clk);
         pulse_complete(order == 1, order == 0);
      end
      while (!l2_flush_req)
         @(posedge clk);
      repeat (rand_range(0, 4)) @(posedge clk);
      l2_flush_complete <= 1'b1;
      @(posedge clk);
      l2_flush_complete <= 1'b0;
      while (in_flush_mode)
         @(posedge clk);
      repeat (2) @(posedge clk);
   endtask

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired before all tests completed");
      $display("test failed");
      $fatal(1, "timeout");
   end

   initial
   begin
      int i;
      int kind;
      int order;

      reset = 1'b1;
      l1i_flush_req = 1'b0;
      l1d_flush_req = 1'b0;
      l1i_flush_complete = 1'b0;
      l1d_flush_complete = 1'b0;
      l2_flush_complete = 1'b0;
      l2_req_valid = 1'b0;
      l2_req = '0;
      mem_req_gnt = 1'b0;
      mem_rsp_valid = 1'b0;
      mem_rsp_data = '0;
      mem_stall = 1'b0;
      inject_rsp = 1'b0;

      for (i = 0; i < RESET_CYCLES; i++)
      begin
         @(posedge clk);
         if (i > 0)
            check_reset_outputs();
      end
      reset <= 1'b0;
      @(posedge clk);

      // random traffic
      for (i = 0; i < N_REQ; i++)
      begin
         push_req(random_req());
         repeat (rand_range(0, 2)) @(posedge clk);
      end
      wait_drain();

      // fill the queue against a stalled memory
      mem_stall <= 1'b1;
      @(posedge clk);
      for (i = 0; i < QUEUE_DEPTH; i++)
         push_req(random_req());
      fork
         push_req(random_req());
         begin
            repeat (12) @(posedge clk);
            mem_stall <= 1'b0;
         end
      join
      wait_drain();

      for (i = 0; i < N_FLUSH; i++)
      begin
         if (i < 5)
         begin
            kind = (i < 2) ? i : 2;
            order = (i < 2) ? 0 : i - 2;
         end
         else
         begin
            kind = rand_range(0, 2);
            order = rand_range(0, 2);
         end
         run_flush(kind, order);
      end

      // response with nothing outstanding
      inject_rsp <= 1'b1;
      @(posedge clk);
      inject_rsp <= 1'b0;
      repeat (10) @(posedge clk);
      assert (bad_rsp) else report_failure("bad_rsp not set after an unexpected response");

      $display("test passed");
      $finish;
   end

endmodule
